// File: include/video_consts.svh
// Video controller constants
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ============================================================
// Bus and video widths.
// ============================================================
`define VIDEO_ADDR_W 32
`define VIDEO_DATA_W 32
`define VIDEO_RGB_W 24
`define VIDEO_POS_W 11

// Region codes in address bits 23:20, anything else is VRAM.
`define VIDEO_REGION_PALETTE 4'he
`define VIDEO_REGION_CTRL 4'hf

// Control register indices from address bits 3:2.
`define VIDEO_REG_OFFSET 2'd0
`define VIDEO_REG_PITCH 2'd1
`define VIDEO_REG_SKIP 2'd2

// ============================================================
// Buffer sizes.
// ============================================================
`define VIDEO_MAX_PITCH 640
`define VIDEO_WB_DEPTH 16
`define VIDEO_PAL_DEPTH 256
`define VIDEO_PAL_ADDR_W 8
`define VIDEO_LINE_WORDS (`VIDEO_MAX_PITCH / 4)
`define VIDEO_LINE_ADDR_W ($clog2(`VIDEO_LINE_WORDS))

`endif

// File: source/video_controller.sv
// Video scan-out controller
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module video_controller #(
	parameter int WB_DEPTH = `VIDEO_WB_DEPTH
) (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_cpu_req,
	input wire i_cpu_we,
	input wire [`VIDEO_ADDR_W-1:0] i_cpu_addr,
	input wire [`VIDEO_DATA_W-1:0] i_cpu_wdata,
	output logic [`VIDEO_DATA_W-1:0] o_cpu_rdata,
	output logic o_cpu_ack,
	input wire i_video_hblank,
	input wire i_video_vblank,
	input wire [`VIDEO_POS_W-1:0] i_video_pos_x,
	output logic [`VIDEO_RGB_W-1:0] o_video_rgb,
	output logic o_vram_a_req,
	output logic o_vram_a_we,
	output logic [`VIDEO_ADDR_W-1:0] o_vram_a_addr,
	output logic [`VIDEO_DATA_W-1:0] o_vram_a_wdata,
	input wire [`VIDEO_DATA_W-1:0] i_vram_a_rdata,
	input wire i_vram_a_ack,
	output logic o_vram_b_req,
	output logic o_vram_b_we,
	output logic [`VIDEO_ADDR_W-1:0] o_vram_b_addr,
	output logic [`VIDEO_DATA_W-1:0] o_vram_b_wdata,
	input wire [`VIDEO_DATA_W-1:0] i_vram_b_rdata,
	input wire i_vram_b_ack
);

	// ============================================================
	// Internal connections.
	// ============================================================
	logic wb_req;
	logic wb_we;
	logic wb_ack;
	logic [`VIDEO_ADDR_W-1:0] wb_addr;
	logic [`VIDEO_DATA_W-1:0] wb_wdata;
	logic [`VIDEO_DATA_W-1:0] wb_rdata;
	logic pal_we;
	logic [`VIDEO_PAL_ADDR_W-1:0] pal_waddr;
	logic [`VIDEO_PAL_ADDR_W-1:0] pal_raddr;
	logic [`VIDEO_RGB_W-1:0] pal_wdata;
	logic [`VIDEO_RGB_W-1:0] pal_rdata;
	logic [`VIDEO_ADDR_W-1:0] read_offset;
	logic [`VIDEO_DATA_W-1:0] pitch;
	video_pkg::skip_t skip;
	logic line_we;
	logic [`VIDEO_LINE_ADDR_W-1:0] line_waddr;
	logic [`VIDEO_LINE_ADDR_W-1:0] line_raddr;
	video_pkg::line_word_t line_wdata;
	video_pkg::line_word_t line_rdata;

	// Port B is read only.
	assign o_vram_b_we = 1'b0;
	assign o_vram_b_wdata = '0;

	video_cpu_decoder u_decoder (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_cpu_req(i_cpu_req), .i_cpu_we(i_cpu_we),
		.i_cpu_addr(i_cpu_addr), .i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata), .o_cpu_ack(o_cpu_ack),
		.o_wb_req(wb_req), .o_wb_we(wb_we), .o_wb_addr(wb_addr),
		.o_wb_wdata(wb_wdata), .i_wb_rdata(wb_rdata), .i_wb_ack(wb_ack),
		.o_pal_we(pal_we), .o_pal_addr(pal_waddr), .o_pal_wdata(pal_wdata),
		.o_read_offset(read_offset), .o_pitch(pitch), .o_skip(skip)
	);

	video_write_buffer #(.DEPTH(WB_DEPTH)) u_write_buffer (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_req(wb_req), .i_we(wb_we), .i_addr(wb_addr), .i_wdata(wb_wdata),
		.o_rdata(wb_rdata), .o_ack(wb_ack),
		.o_bus_req(o_vram_a_req), .o_bus_we(o_vram_a_we),
		.o_bus_addr(o_vram_a_addr), .o_bus_wdata(o_vram_a_wdata),
		.i_bus_rdata(i_vram_a_rdata), .i_bus_ack(i_vram_a_ack)
	);

	video_line_fetcher u_line_fetcher (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_hblank(i_video_hblank), .i_vblank(i_video_vblank),
		.i_read_offset(read_offset), .i_pitch(pitch), .i_skip(skip),
		.o_vram_req(o_vram_b_req), .o_vram_addr(o_vram_b_addr),
		.i_vram_rdata(i_vram_b_rdata), .i_vram_ack(i_vram_b_ack),
		.o_line_we(line_we), .o_line_addr(line_waddr), .o_line_wdata(line_wdata)
	);

	video_pixel_path u_pixel_path (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_pos_x(i_video_pos_x), .i_skip(skip),
		.o_line_raddr(line_raddr), .i_line_rdata(line_rdata),
		.o_pal_raddr(pal_raddr), .i_pal_rdata(pal_rdata), .o_rgb(o_video_rgb)
	);

	video_dual_port_ram #(.WIDTH(`VIDEO_RGB_W), .DEPTH(`VIDEO_PAL_DEPTH)) palette_ram (
		.i_clock(i_clock), .i_we(pal_we), .i_waddr(pal_waddr), .i_wdata(pal_wdata),
		.i_raddr(pal_raddr), .o_rdata(pal_rdata)
	);

	video_dual_port_ram #(.WIDTH(`VIDEO_DATA_W), .DEPTH(`VIDEO_LINE_WORDS)) line_ram (
		.i_clock(i_clock), .i_we(line_we), .i_waddr(line_waddr), .i_wdata(line_wdata),
		.i_raddr(line_raddr), .o_rdata(line_rdata)
	);

endmodule

`default_nettype wire

// File: source/video_cpu_decoder.sv
// Processor bus decoder
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module video_cpu_decoder (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_cpu_req,
	input wire i_cpu_we,
	input wire [`VIDEO_ADDR_W-1:0] i_cpu_addr,
	input wire [`VIDEO_DATA_W-1:0] i_cpu_wdata,
	output logic [`VIDEO_DATA_W-1:0] o_cpu_rdata,
	output logic o_cpu_ack,
	output logic o_wb_req,
	output logic o_wb_we,
	output logic [`VIDEO_ADDR_W-1:0] o_wb_addr,
	output logic [`VIDEO_DATA_W-1:0] o_wb_wdata,
	input wire [`VIDEO_DATA_W-1:0] i_wb_rdata,
	input wire i_wb_ack,
	output logic o_pal_we,
	output logic [`VIDEO_PAL_ADDR_W-1:0] o_pal_addr,
	output logic [`VIDEO_RGB_W-1:0] o_pal_wdata,
	output logic [`VIDEO_ADDR_W-1:0] o_read_offset,
	output logic [`VIDEO_DATA_W-1:0] o_pitch,
	output video_pkg::skip_t o_skip
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_VRAM = 3'd1;
	localparam logic [2:0] ST_PALETTE = 3'd2;
	localparam logic [2:0] ST_CONTROL = 3'd3;
	localparam logic [2:0] ST_RELEASE = 3'd4;

	logic [2:0] state;
	logic [3:0] region;
	logic [1:0] reg_idx;

	assign region = i_cpu_addr[23:20];
	assign reg_idx = i_cpu_addr[3:2];

	// ============================================================
	// Access FSM and control registers.
	// ============================================================
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			o_cpu_ack <= 1'b0;
			o_wb_req <= 1'b0;
			o_wb_we <= 1'b0;
			o_pal_we <= 1'b0;
			o_read_offset <= '0;
			o_pitch <= '0;
			o_skip <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Wait out the tail of the previous buffer handshake.
					if (i_cpu_req && !i_wb_ack) begin
						if (region == `VIDEO_REGION_PALETTE) begin
							o_pal_we <= i_cpu_we;
							state <= ST_PALETTE;
						end else if (region == `VIDEO_REGION_CTRL) begin
							state <= ST_CONTROL;
						end else begin
							o_wb_req <= 1'b1;
							o_wb_we <= i_cpu_we;
							state <= ST_VRAM;
						end
					end
				end
				ST_VRAM: begin
					if (i_wb_ack) begin
						o_wb_req <= 1'b0;
						o_cpu_ack <= 1'b1;
						state <= ST_RELEASE;
					end
				end
				ST_PALETTE: begin
					o_pal_we <= 1'b0;
					state <= ST_RELEASE;
				end
				ST_CONTROL: begin
					if (i_cpu_we) begin
						case (reg_idx)
							`VIDEO_REG_OFFSET: o_read_offset <= i_cpu_wdata;
							`VIDEO_REG_PITCH: o_pitch <= i_cpu_wdata;
							`VIDEO_REG_SKIP: o_skip <= i_cpu_wdata[1:0];
							default: ;
						endcase
					end
					state <= ST_RELEASE;
				end
				ST_RELEASE: begin
					// Ack follows req until the master lets go.
					o_cpu_ack <= i_cpu_req;
					if (!i_cpu_req) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Latched addresses, write data and read data.
	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE) begin
			o_wb_addr <= {{(`VIDEO_ADDR_W-24){1'b0}}, i_cpu_addr[23:0]};
			o_wb_wdata <= i_cpu_wdata;
			o_pal_addr <= i_cpu_addr[9:2];
			o_pal_wdata <= i_cpu_wdata[`VIDEO_RGB_W-1:0];
		end
		if ((state == ST_VRAM) && i_wb_ack) begin
			o_cpu_rdata <= i_wb_rdata;
		end else if (state == ST_PALETTE) begin
			o_cpu_rdata <= '0;
		end else if (state == ST_CONTROL) begin
			case (reg_idx)
				`VIDEO_REG_OFFSET: o_cpu_rdata <= o_read_offset;
				`VIDEO_REG_PITCH: o_cpu_rdata <= o_pitch;
				`VIDEO_REG_SKIP: o_cpu_rdata <= {{(`VIDEO_DATA_W-2){1'b0}}, o_skip};
				default: o_cpu_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/video_dual_port_ram.sv
// Dual port block RAM
`timescale 1ns/1ps
`default_nettype none

module video_dual_port_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256
) (
	input wire i_clock,
	input wire i_we,
	input wire [$clog2(DEPTH)-1:0] i_waddr,
	input wire [WIDTH-1:0] i_wdata,
	input wire [$clog2(DEPTH)-1:0] i_raddr,
	output logic [WIDTH-1:0] o_rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Write port.
	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Registered read, one cycle latency.
	always_ff @(posedge i_clock) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

`default_nettype wire

// File: source/video_line_fetcher.sv
// Scan line fetcher
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module video_line_fetcher (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_hblank,
	input wire i_vblank,
	input wire [`VIDEO_ADDR_W-1:0] i_read_offset,
	input wire [`VIDEO_DATA_W-1:0] i_pitch,
	input wire video_pkg::skip_t i_skip,
	output logic o_vram_req,
	output logic [`VIDEO_ADDR_W-1:0] o_vram_addr,
	input wire [`VIDEO_DATA_W-1:0] i_vram_rdata,
	input wire i_vram_ack,
	output logic o_line_we,
	output logic [`VIDEO_LINE_ADDR_W-1:0] o_line_addr,
	output video_pkg::line_word_t o_line_wdata
);

	localparam logic [1:0] FT_IDLE = 2'd0;
	localparam logic [1:0] FT_REQ = 2'd1;
	localparam logic [1:0] FT_WAIT = 2'd2;

	// Two sync stages plus the previous value for edge detection.
	logic [2:0] hb_sync;
	logic [2:0] vb_sync;
	logic [`VIDEO_ADDR_W-1:0] row;
	logic odd_line;
	logic [`VIDEO_DATA_W-3:0] word_cnt;
	logic [`VIDEO_DATA_W-3:0] words;
	logic [1:0] state;
	logic hb_fall;
	logic vb_rise;
	logic start;
	logic next_word;

	assign words = i_pitch[`VIDEO_DATA_W-1:2];
	assign hb_fall = hb_sync[2] && !hb_sync[1];
	assign vb_rise = vb_sync[1] && !vb_sync[2];
	// Odd lines under line repeat keep the old buffer contents.
	assign start = hb_fall && !vb_sync[1] && (state == FT_IDLE) && (words != '0)
		&& (!i_skip.line_repeat || !odd_line);
	assign next_word = (state == FT_WAIT) && !i_vram_ack && (word_cnt != words);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hb_sync <= '0;
			vb_sync <= '0;
			row <= '0;
			odd_line <= 1'b0;
			word_cnt <= '0;
			state <= FT_IDLE;
			o_vram_req <= 1'b0;
			o_line_we <= 1'b0;
		end else begin
			hb_sync <= {hb_sync[1:0], i_hblank};
			vb_sync <= {vb_sync[1:0], i_vblank};
			o_line_we <= 1'b0;

			if (vb_rise) begin
				row <= '0;
				odd_line <= 1'b0;
			end else if (hb_fall && !vb_sync[1]) begin
				odd_line <= !odd_line;
			end
			if (start) begin
				row <= row + i_pitch;
				word_cnt <= '0;
				o_vram_req <= 1'b1;
				state <= FT_REQ;
			end

			// ====================================================
			// One word per port B handshake.
			// ====================================================
			case (state)
				FT_REQ: begin
					if (i_vram_ack) begin
						o_vram_req <= 1'b0;
						o_line_we <= 1'b1;
						word_cnt <= word_cnt + 1'b1;
						state <= FT_WAIT;
					end
				end
				FT_WAIT: begin
					if (next_word) begin
						o_vram_req <= 1'b1;
						state <= FT_REQ;
					end else if (!i_vram_ack) begin
						state <= FT_IDLE;
					end
				end
				default: ;
			endcase
		end
	end

	// Burst address and line buffer data.
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_vram_addr <= i_read_offset + row;
		end else if (next_word) begin
			o_vram_addr <= o_vram_addr + 4;
		end
		if ((state == FT_REQ) && i_vram_ack) begin
			o_line_addr <= word_cnt[`VIDEO_LINE_ADDR_W-1:0];
			o_line_wdata.raw <= i_vram_rdata;
		end
	end

endmodule

`default_nettype wire

// File: source/video_pixel_path.sv
// Pixel lookup pipeline
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module video_pixel_path (
	input wire i_clock,
	input wire i_rst_n,
	input wire [`VIDEO_POS_W-1:0] i_pos_x,
	input wire video_pkg::skip_t i_skip,
	output logic [`VIDEO_LINE_ADDR_W-1:0] o_line_raddr,
	input wire video_pkg::line_word_t i_line_rdata,
	output logic [`VIDEO_PAL_ADDR_W-1:0] o_pal_raddr,
	input wire [`VIDEO_RGB_W-1:0] i_pal_rdata,
	output logic [`VIDEO_RGB_W-1:0] o_rgb
);

	logic [`VIDEO_POS_W-3:0] column;
	logic [1:0] byte_sel;
	logic [1:0] byte_sel_d;

	// Column and byte within the word, halved when doubling.
	always_comb begin
		if (i_skip.pixel_double) begin
			column = {1'b0, i_pos_x[`VIDEO_POS_W-1:3]};
			byte_sel = i_pos_x[2:1];
		end else begin
			column = i_pos_x[`VIDEO_POS_W-1:2];
			byte_sel = i_pos_x[1:0];
		end
	end

	assign o_line_raddr = column[`VIDEO_LINE_ADDR_W-1:0];
	assign o_pal_raddr = i_line_rdata.pix[byte_sel_d];

	// Byte select lines up with the line RAM output.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			byte_sel_d <= '0;
			o_rgb <= '0;
		end else begin
			byte_sel_d <= byte_sel;
			o_rgb <= i_pal_rdata;
		end
	end

endmodule

`default_nettype wire

// File: source/video_pkg.sv
// Video controller types
`default_nettype none

`include "video_consts.svh"

package video_pkg;

	// One line buffer word.
	// Seen either raw or as four pixel indices, pixel 0 in the low byte.
	typedef union packed {
		logic [`VIDEO_DATA_W-1:0] raw;
		logic [`VIDEO_DATA_W/8-1:0][7:0] pix;
	} line_word_t;

	// Skip mode register.
	typedef struct packed {
		logic line_repeat;
		logic pixel_double;
	} skip_t;

endpackage

`default_nettype wire

// File: source/video_write_buffer.sv
// VRAM write buffer
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module video_write_buffer #(
	parameter int DEPTH = `VIDEO_WB_DEPTH
) (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_req,
	input wire i_we,
	input wire [`VIDEO_ADDR_W-1:0] i_addr,
	input wire [`VIDEO_DATA_W-1:0] i_wdata,
	output logic [`VIDEO_DATA_W-1:0] o_rdata,
	output logic o_ack,
	output logic o_bus_req,
	output logic o_bus_we,
	output logic [`VIDEO_ADDR_W-1:0] o_bus_addr,
	output logic [`VIDEO_DATA_W-1:0] o_bus_wdata,
	input wire [`VIDEO_DATA_W-1:0] i_bus_rdata,
	input wire i_bus_ack
);

	// DEPTH must be a power of two, pointers carry one wrap bit.
	localparam int AW = $clog2(DEPTH);
	localparam logic [1:0] BUS_IDLE = 2'd0;
	localparam logic [1:0] BUS_REQ = 2'd1;
	localparam logic [1:0] BUS_DONE = 2'd2;

	logic [`VIDEO_ADDR_W-1:0] fifo_addr [DEPTH];
	logic [`VIDEO_DATA_W-1:0] fifo_data [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [1:0] bus_state;
	logic rd_active;
	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign push = i_req && i_we && !o_ack && !full;
	assign pop = (bus_state == BUS_REQ) && i_bus_ack && !rd_active;

	// ============================================================
	// Pointers, inner handshake and port A sequencing.
	// ============================================================
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_ack <= 1'b0;
			o_bus_req <= 1'b0;
			o_bus_we <= 1'b0;
			rd_active <= 1'b0;
			bus_state <= BUS_IDLE;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (!i_req) begin
				o_ack <= 1'b0;
			end else if (push) begin
				o_ack <= 1'b1;
			end

			case (bus_state)
				BUS_IDLE: begin
					// Queued writes go first, reads wait for an empty FIFO.
					if (!empty) begin
						o_bus_req <= 1'b1;
						o_bus_we <= 1'b1;
						bus_state <= BUS_REQ;
					end else if (i_req && !i_we && !o_ack) begin
						o_bus_req <= 1'b1;
						o_bus_we <= 1'b0;
						rd_active <= 1'b1;
						bus_state <= BUS_REQ;
					end
				end
				BUS_REQ: begin
					if (i_bus_ack) begin
						o_bus_req <= 1'b0;
						bus_state <= BUS_DONE;
						if (rd_active) begin
							o_ack <= 1'b1;
							rd_active <= 1'b0;
						end
					end
				end
				BUS_DONE: begin
					if (!i_bus_ack) begin
						bus_state <= BUS_IDLE;
					end
				end
				default: bus_state <= BUS_IDLE;
			endcase
		end
	end

	// FIFO storage and bus payload.
	always_ff @(posedge i_clock) begin
		if (push) begin
			fifo_addr[wr_ptr[AW-1:0]] <= i_addr;
			fifo_data[wr_ptr[AW-1:0]] <= i_wdata;
		end
		if (bus_state == BUS_IDLE) begin
			if (!empty) begin
				o_bus_addr <= fifo_addr[rd_ptr[AW-1:0]];
				o_bus_wdata <= fifo_data[rd_ptr[AW-1:0]];
			end else begin
				o_bus_addr <= i_addr;
				o_bus_wdata <= i_wdata;
			end
		end
		if ((bus_state == BUS_REQ) && i_bus_ack && rd_active) begin
			o_rdata <= i_bus_rdata;
		end
	end

endmodule

`default_nettype wire

// File: verif/video_controller_tb.sv
// Video controller testbench
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module video_controller_tb;

	localparam int OP_WR = 0;
	localparam int OP_RD = 1;
	localparam int OP_FRAME = 2;
	localparam int OP_SCAN = 3;
	localparam int TIMEOUT = 500;
	localparam logic [31:0] LINE_OFFSET = 32'h0000_0100;
	localparam logic [31:0] LINE_PITCH = 32'd16;
	localparam logic [31:0] TEST_BASE = 32'h0000_0800;
	localparam logic [31:0] CTRL_BASE = {8'h00, `VIDEO_REGION_CTRL, 20'h00000};
	localparam logic [31:0] PAL_BASE = {8'h00, `VIDEO_REGION_PALETTE, 20'h00000};
	localparam logic [31:0] OFFSET_ADDR = {CTRL_BASE[31:4], `VIDEO_REG_OFFSET, 2'b00};
	localparam logic [31:0] PITCH_ADDR = {CTRL_BASE[31:4], `VIDEO_REG_PITCH, 2'b00};
	localparam logic [31:0] SKIP_ADDR = {CTRL_BASE[31:4], `VIDEO_REG_SKIP, 2'b00};

	logic clock;
	logic rst_n;
	logic cpu_req;
	logic cpu_we;
	logic [31:0] cpu_addr;
	logic [31:0] cpu_wdata;
	logic [31:0] cpu_rdata;
	logic cpu_ack;
	logic hblank;
	logic vblank;
	logic [`VIDEO_POS_W-1:0] pos_x;
	logic [`VIDEO_RGB_W-1:0] video_rgb;
	logic vram_a_req;
	logic vram_a_we;
	logic [31:0] vram_a_addr;
	logic [31:0] vram_a_wdata;
	logic [31:0] vram_a_rdata;
	logic vram_a_ack;
	logic vram_b_req;
	logic vram_b_we;
	logic [31:0] vram_b_addr;
	logic [31:0] vram_b_wdata;
	logic [31:0] vram_b_rdata;
	logic vram_b_ack;
	logic [1:0] cur_skip;

	// Stimulus table.
	int op_tab [512];
	logic [31:0] addr_tab [512];
	logic [31:0] data_tab [512];
	logic [31:0] exp_tab [512];
	int num_steps = 0;

	video_controller DUT (
		.i_clock(clock), .i_rst_n(rst_n),
		.i_cpu_req(cpu_req), .i_cpu_we(cpu_we), .i_cpu_addr(cpu_addr),
		.i_cpu_wdata(cpu_wdata), .o_cpu_rdata(cpu_rdata), .o_cpu_ack(cpu_ack),
		.i_video_hblank(hblank), .i_video_vblank(vblank), .i_video_pos_x(pos_x),
		.o_video_rgb(video_rgb),
		.o_vram_a_req(vram_a_req), .o_vram_a_we(vram_a_we), .o_vram_a_addr(vram_a_addr),
		.o_vram_a_wdata(vram_a_wdata), .i_vram_a_rdata(vram_a_rdata),
		.i_vram_a_ack(vram_a_ack),
		.o_vram_b_req(vram_b_req), .o_vram_b_we(vram_b_we), .o_vram_b_addr(vram_b_addr),
		.o_vram_b_wdata(vram_b_wdata), .i_vram_b_rdata(vram_b_rdata),
		.i_vram_b_ack(vram_b_ack)
	);

	video_vram_model vram (
		.i_clock(clock),
		.i_a_req(vram_a_req), .i_a_we(vram_a_we), .i_a_addr(vram_a_addr),
		.i_a_wdata(vram_a_wdata), .o_a_rdata(vram_a_rdata), .o_a_ack(vram_a_ack),
		.i_b_req(vram_b_req), .i_b_addr(vram_b_addr),
		.o_b_rdata(vram_b_rdata), .o_b_ack(vram_b_ack)
	);

	always #5 clock = ~clock;

	// ============================================================
	// Reference data and checks.
	// ============================================================
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
	endfunction

	function automatic logic [23:0] palette_color(input logic [7:0] idx);
		return {idx, idx ^ 8'hc3, ~idx};
	endfunction

	function automatic logic is_vram(input logic [31:0] addr);
		return (addr[23:20] != `VIDEO_REGION_PALETTE) && (addr[23:20] != `VIDEO_REGION_CTRL);
	endfunction

	// Colour for a column of a row, following the skip mode.
	function automatic logic [23:0] expected_rgb(input int row, input int x);
		int col;
		int sel;
		logic [31:0] word;
		if (cur_skip[0]) begin
			col = x / 8;
			sel = (x / 2) % 4;
		end else begin
			col = x / 4;
			sel = x % 4;
		end
		word = fill_word(LINE_OFFSET + row * LINE_PITCH + 4 * col);
		return palette_color(word[8 * sel +: 8]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp) else begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic add_step(input int op, input logic [31:0] addr, input logic [31:0] data,
		input logic [31:0] exp);
		op_tab[num_steps] = op;
		addr_tab[num_steps] = addr;
		data_tab[num_steps] = data;
		exp_tab[num_steps] = exp;
		num_steps++;
	endtask

	task automatic build_table();
		int i;
		add_step(OP_WR, OFFSET_ADDR, LINE_OFFSET, 0);
		add_step(OP_RD, OFFSET_ADDR, 0, LINE_OFFSET);
		add_step(OP_WR, PITCH_ADDR, LINE_PITCH, 0);
		add_step(OP_RD, PITCH_ADDR, 0, LINE_PITCH);
		add_step(OP_WR, SKIP_ADDR, 32'hffff_fffe, 0);
		add_step(OP_RD, SKIP_ADDR, 0, 32'h2);
		add_step(OP_WR, SKIP_ADDR, 0, 0);
		add_step(OP_RD, SKIP_ADDR, 0, 0);
		// Posted writes, then reads of the same words.
		for (i = 0; i < 8; i++) begin
			add_step(OP_WR, TEST_BASE + 4 * i, fill_word(TEST_BASE + 4 * i), 0);
		end
		for (i = 0; i < 8; i++) begin
			add_step(OP_RD, TEST_BASE + 4 * i, 0, fill_word(TEST_BASE + 4 * i));
		end
		// Three rows of pixel data, then the whole palette.
		for (i = 0; i < 3 * LINE_PITCH / 4; i++) begin
			add_step(OP_WR, LINE_OFFSET + 4 * i, fill_word(LINE_OFFSET + 4 * i), 0);
		end
		for (i = 0; i < `VIDEO_PAL_DEPTH; i++) begin
			add_step(OP_WR, PAL_BASE + 4 * i, palette_color(i), 0);
		end
		add_step(OP_FRAME, 0, 0, 0);
		add_step(OP_SCAN, 0, LINE_PITCH, LINE_PITCH / 4);
		add_step(OP_SCAN, 1, LINE_PITCH, LINE_PITCH / 4);
		// Pixel doubling.
		add_step(OP_WR, SKIP_ADDR, 1, 0);
		add_step(OP_FRAME, 0, 0, 0);
		add_step(OP_SCAN, 0, 2 * LINE_PITCH, LINE_PITCH / 4);
		// Line repeat, the second line fetches nothing.
		add_step(OP_WR, SKIP_ADDR, 2, 0);
		add_step(OP_FRAME, 0, 0, 0);
		add_step(OP_SCAN, 0, LINE_PITCH, LINE_PITCH / 4);
		add_step(OP_SCAN, 0, LINE_PITCH, 0);
		add_step(OP_SCAN, 1, LINE_PITCH, LINE_PITCH / 4);
	endtask

	// ============================================================
	// Processor bus and video timing.
	// ============================================================
	task automatic bus_access(input logic we, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		@(negedge clock);
		cpu_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
		cpu_req = 1'b1;
		n = 0;
		while (!cpu_ack) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) report_timeout("processor bus ack never rose");
		end
		rdata = cpu_rdata;
		cpu_req = 1'b0;
		n = 0;
		while (cpu_ack) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) report_timeout("processor bus ack never fell");
		end
	endtask

	task automatic frame_start();
		@(negedge clock);
		vblank = 1'b1;
		repeat (4) @(negedge clock);
		vblank = 1'b0;
		repeat (4) @(negedge clock);
	endtask

	task automatic scan_line(input int row, input int pixels, input int words);
		int base;
		int n;
		int k;
		logic [23:0] want [128];
		base = vram.b_count;
		@(negedge clock);
		hblank = 1'b1;
		repeat (4) @(negedge clock);
		hblank = 1'b0;
		if (words > 0) begin
			n = 0;
			while ((vram.b_count - base < words) || vram_b_req || vram_b_ack) begin
				@(negedge clock);
				n++;
				if (n > TIMEOUT) report_timeout("line burst did not complete");
				check_value("o_vram_b_we", 0, vram_b_we);
			end
		end
		// Window covers the blank synchroniser and one more request.
		for (k = 0; k < 8; k++) begin
			@(negedge clock);
			check_value("o_vram_b_we", 0, vram_b_we);
		end
		check_value("port B word count", words, vram.b_count - base);
		for (k = 0; k < words; k++) begin
			check_value("o_vram_b_addr", LINE_OFFSET + row * LINE_PITCH + 4 * k,
				vram.b_addr_log[base + k]);
		end
		// Colour shows up three clocks after the position.
		for (k = 0; k < pixels + 3; k++) begin
			@(negedge clock);
			if (k >= 3) begin
				check_value("o_video_rgb", want[k - 3], video_rgb);
			end
			if (k < pixels) begin
				want[k] = expected_rgb(row, k);
				pos_x = `VIDEO_POS_W'(k);
			end
		end
	endtask

	task automatic apply_step(input int i);
		logic [31:0] rdata;
		case (op_tab[i])
			OP_WR: begin
				bus_access(1'b1, addr_tab[i], data_tab[i], rdata);
				if (addr_tab[i] == SKIP_ADDR) begin
					cur_skip = data_tab[i][1:0];
				end
			end
			OP_RD: begin
				bus_access(1'b0, addr_tab[i], 0, rdata);
				check_value("o_cpu_rdata", exp_tab[i], rdata);
			end
			OP_FRAME: frame_start();
			default: scan_line(addr_tab[i], data_tab[i], exp_tab[i]);
		endcase
	endtask

	// Port A writes in table order, and the memory holds them.
	task automatic check_write_log();
		int i;
		int n;
		n = 0;
		for (i = 0; i < num_steps; i++) begin
			if ((op_tab[i] == OP_WR) && is_vram(addr_tab[i])) begin
				check_value("o_vram_a_addr", addr_tab[i], vram.a_wr_addr[n]);
				check_value("o_vram_a_wdata", data_tab[i], vram.a_wr_data[n]);
				check_value("vram memory", data_tab[i], vram.mem[addr_tab[i][11:2]]);
				n++;
			end
		end
		check_value("port A write count", n, vram.a_wr_count);
	endtask

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		pos_x = '0;
		cur_skip = 2'd0;
		build_table();
		repeat (10) @(negedge clock);
		rst_n = 1'b1;
		check_value("o_cpu_ack", 0, cpu_ack);
		check_value("o_vram_a_req", 0, vram_a_req);
		check_value("o_vram_b_req", 0, vram_b_req);
		for (int i = 0; i < num_steps; i++) begin
			apply_step(i);
		end
		check_write_log();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/video_vram_model.sv
// Two port VRAM model
`timescale 1ns/1ps
`default_nettype none

module video_vram_model (
	input wire i_clock,
	input wire i_a_req,
	input wire i_a_we,
	input wire [31:0] i_a_addr,
	input wire [31:0] i_a_wdata,
	output logic [31:0] o_a_rdata,
	output logic o_a_ack,
	input wire i_b_req,
	input wire [31:0] i_b_addr,
	output logic [31:0] o_b_rdata,
	output logic o_b_ack
);

	// Word storage plus logs of port A writes and port B addresses.
	logic [31:0] mem [1024];
	logic [31:0] a_wr_addr [64];
	logic [31:0] a_wr_data [64];
	logic [31:0] b_addr_log [64];
	int a_wr_count = 0;
	int b_count = 0;
	logic [31:0] lfsr = 32'h69d8_d8f6;
	logic [1:0] a_wait = 2'd0;
	logic [1:0] b_wait = 2'd0;

	// Fibonacci LFSR, taps 32 22 2 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per delay bit.
	task automatic draw_delay(output logic [1:0] delay);
		lfsr = lfsr_next(lfsr);
		delay[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		delay[1] = lfsr[0];
	endtask

	initial begin
		o_a_ack = 1'b0;
		o_b_ack = 1'b0;
	end

	// ============================================================
	// Four phase responders, one word per request.
	// ============================================================
	always @(posedge i_clock) begin
		if (!i_a_req) begin
			o_a_ack <= 1'b0;
			draw_delay(a_wait);
		end else if (!o_a_ack) begin
			if (a_wait != 2'd0) begin
				a_wait = a_wait - 1'b1;
			end else begin
				if (i_a_we) begin
					mem[i_a_addr[11:2]] = i_a_wdata;
					a_wr_addr[a_wr_count] = i_a_addr;
					a_wr_data[a_wr_count] = i_a_wdata;
					a_wr_count++;
				end
				o_a_rdata <= mem[i_a_addr[11:2]];
				o_a_ack <= 1'b1;
			end
		end

		// Port B only reads.
		if (!i_b_req) begin
			o_b_ack <= 1'b0;
			draw_delay(b_wait);
		end else if (!o_b_ack) begin
			if (b_wait != 2'd0) begin
				b_wait = b_wait - 1'b1;
			end else begin
				b_addr_log[b_count] = i_b_addr;
				b_count++;
				o_b_rdata <= mem[i_b_addr[11:2]];
				o_b_ack <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: video_controller.f
+incdir+include
source/video_pkg.sv
source/video_dual_port_ram.sv
source/video_write_buffer.sv
source/video_cpu_decoder.sv
source/video_line_fetcher.sv
source/video_pixel_path.sv
source/video_controller.sv
verif/video_vram_model.sv
verif/video_controller_tb.sv
